//--- logic/bridge_pkg.sv
package bridge_pkg;

   localparam int reg_width_lp       = 32;
   localparam int core_addr_width_lp = 64;
   localparam int mem_addr_width_lp  = 32;

   // Core DRAM window starts at 0x8000_0000
   localparam logic [mem_addr_width_lp-1:0] dram_flip_lp = 32'h8000_0000;

   // 241 MiB of usable DRAM
   localparam logic [mem_addr_width_lp-1:0] mem_limit_lp = 32'h0F10_0000;

   // Footprint map, 8 MiB per region
   localparam int footprint_regions_lp = 128;
   localparam int region_msb_lp        = 29;
   localparam int region_lsb_lp        = 23;
   localparam int region_width_lp      = region_msb_lp - region_lsb_lp + 1;

   localparam int mbox_depth_lp     = 4;
   localparam int mbox_ptr_width_lp = $clog2(mbox_depth_lp);

   typedef logic [mbox_ptr_width_lp:0] mbox_count_t;

   typedef enum logic [2:0] {
      CSR_SYS_RUN   = 3'd0
      ,CSR_STATUS    = 3'd1
      ,CSR_DRAM_BASE = 3'd2
      ,CSR_CORE_RUN  = 3'd3
      ,CSR_FOOT0     = 3'd4
      ,CSR_FOOT1     = 3'd5
      ,CSR_FOOT2     = 3'd6
      ,CSR_FOOT3     = 3'd7
   } csr_addr_e;

   typedef struct packed {
      csr_addr_e               addr;
      logic [reg_width_lp-1:0] data;
   } csr_wr_t;

   typedef struct packed {
      logic                         is_write;
      logic [mem_addr_width_lp-1:0] addr;
   } host_req_t;

   typedef struct packed {
      logic                          is_write;
      logic [core_addr_width_lp-1:0] addr;
   } dram_req_t;

   typedef struct packed {
      logic                          we;
      logic [core_addr_width_lp-1:0] addr;
      logic [core_addr_width_lp-1:0] data;
   } io_req_t;

   // One host-visible mailbox word
   typedef struct packed {
      logic        v;
      logic [22:0] addr;
      logic [7:0]  data;
   } mbox_word_t;

endpackage

//--- logic/csr_bank.sv
`timescale 1ns/1ps

module csr_bank (
   input  logic                                        clk_i
   ,input  logic                                       reset_i

   ,input  logic                                       csr_wr_v_i
   ,input  bridge_pkg::csr_wr_t                        csr_wr_i

   ,input  logic                                       csr_rd_v_i
   ,input  bridge_pkg::csr_addr_e                      csr_rd_addr_i

   ,input  logic [bridge_pkg::footprint_regions_lp-1:0] footprint_i
   ,input  logic                                       high_seen_i
   ,input  logic                                       overflow_i

   ,output logic                                       sys_reset_o
   ,output logic                                       core_reset_o
   ,output logic [bridge_pkg::reg_width_lp-1:0]        dram_base_o

   ,output logic                                       csr_rd_v_o
   ,output logic [bridge_pkg::reg_width_lp-1:0]        csr_rd_data_o
);

   import bridge_pkg::*;

   localparam int foot_words_lp = footprint_regions_lp / reg_width_lp;

   logic                    sys_run_r;
   logic                    core_run_r;
   logic [reg_width_lp-1:0] dram_base_r;
   logic [reg_width_lp-1:0] rd_data_n;

   logic [foot_words_lp-1:0][reg_width_lp-1:0] foot_words;

   // Writable registers, read-only addresses fall through
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         sys_run_r   <= 1'b0;
         core_run_r  <= 1'b0;
         dram_base_r <= '0;
      end else if (csr_wr_v_i) begin
         case (csr_wr_i.addr)
            CSR_SYS_RUN:   sys_run_r   <= csr_wr_i.data[0];
            CSR_DRAM_BASE: dram_base_r <= csr_wr_i.data;
            CSR_CORE_RUN:  core_run_r  <= csr_wr_i.data[0];
            default: begin
            end
         endcase
      end
   end

   // Core reset nests inside the system reset
   assign sys_reset_o  = reset_i | ~sys_run_r;
   assign core_reset_o = sys_reset_o | ~core_run_r;
   assign dram_base_o  = dram_base_r;

   assign foot_words = footprint_i;

   always_comb begin
      rd_data_n = '0;
      case (csr_rd_addr_i)
         CSR_SYS_RUN:   rd_data_n = {{(reg_width_lp-1){1'b0}}, sys_run_r};
         CSR_STATUS:    rd_data_n = {{(reg_width_lp-2){1'b0}}, overflow_i, high_seen_i};
         CSR_DRAM_BASE: rd_data_n = dram_base_r;
         CSR_CORE_RUN:  rd_data_n = {{(reg_width_lp-1){1'b0}}, core_run_r};
         CSR_FOOT0:     rd_data_n = foot_words[0];
         CSR_FOOT1:     rd_data_n = foot_words[1];
         CSR_FOOT2:     rd_data_n = foot_words[2];
         CSR_FOOT3:     rd_data_n = foot_words[3];
         default:       rd_data_n = '0;
      endcase
   end

   // Read answer one cycle after the strobe
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         csr_rd_v_o <= 1'b0;
      end else begin
         csr_rd_v_o <= csr_rd_v_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (csr_rd_v_i) begin
         csr_rd_data_o <= rd_data_n;
      end
   end

endmodule

//--- logic/addr_remap.sv
`timescale 1ns/1ps

module addr_remap (
   input  logic                                      clk_i
   ,input  logic                                     reset_i
   ,input  logic                                     sys_reset_i
   ,input  logic [bridge_pkg::mem_addr_width_lp-1:0] dram_base_i

   ,input  logic                                     host_req_v_i
   ,input  bridge_pkg::host_req_t                    host_req_i

   ,input  logic                                     dram_req_v_i
   ,input  bridge_pkg::dram_req_t                    dram_req_i

   ,output logic                                     core_req_v_o
   ,output logic [bridge_pkg::core_addr_width_lp-1:0] core_addr_o
   ,output logic                                     core_is_write_o

   ,output logic                                     mem_req_v_o
   ,output logic [bridge_pkg::mem_addr_width_lp-1:0] mem_addr_o
   ,output logic                                     mem_is_write_o
   ,output logic [bridge_pkg::region_width_lp-1:0]   region_o

   ,output logic                                     high_seen_o
);

   import bridge_pkg::*;

   logic [core_addr_width_lp-1:0] host_xlat;
   logic [mem_addr_width_lp-1:0]  dram_offset;
   logic                          dram_high;

   // Host 0x0xxx_xxxx maps to core 0x8xxx_xxxx, host 0x2xxx_xxxx to core 0x0xxx_xxxx
   assign host_xlat = {32'b0, ~host_req_i.addr[29], 3'b0, host_req_i.addr[27:0]};

   // Offset of the request inside DRAM
   assign dram_offset = dram_req_i.addr[mem_addr_width_lp-1:0] ^ dram_flip_lp;
   assign dram_high   = dram_offset >= mem_limit_lp;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         core_req_v_o <= 1'b0;
      end else begin
         core_req_v_o <= host_req_v_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (host_req_v_i) begin
         core_addr_o     <= host_xlat;
         core_is_write_o <= host_req_i.is_write;
      end
   end

   // No DRAM traffic leaves while the system is held in reset
   always_ff @(posedge clk_i) begin
      if (sys_reset_i) begin
         mem_req_v_o <= 1'b0;
      end else begin
         mem_req_v_o <= dram_req_v_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (dram_req_v_i) begin
         mem_addr_o     <= dram_offset + dram_base_i;
         mem_is_write_o <= dram_req_i.is_write;
         region_o       <= dram_req_i.addr[region_msb_lp:region_lsb_lp];
      end
   end

   // Sticky out-of-range flag
   always_ff @(posedge clk_i) begin
      if (sys_reset_i) begin
         high_seen_o <= 1'b0;
      end else if (dram_req_v_i && dram_high) begin
         high_seen_o <= 1'b1;
      end
   end

endmodule

//--- logic/mem_footprint.sv
`timescale 1ns/1ps

module mem_footprint (
   input  logic                                         clk_i
   ,input  logic                                        sys_reset_i

   ,input  logic                                        mark_v_i
   ,input  logic [bridge_pkg::region_width_lp-1:0]      region_i

   ,output logic [bridge_pkg::footprint_regions_lp-1:0] footprint_o
);

   import bridge_pkg::*;

   logic [footprint_regions_lp-1:0] footprint_r;

   // One bit per region touched since the system left reset
   always_ff @(posedge clk_i) begin
      if (sys_reset_i) begin
         footprint_r <= '0;
      end else if (mark_v_i) begin
         footprint_r[region_i] <= 1'b1;
      end
   end

   assign footprint_o = footprint_r;

endmodule

//--- logic/io_mailbox.sv
`timescale 1ns/1ps

module io_mailbox (
   input  logic                    clk_i
   ,input  logic                   sys_reset_i

   ,input  logic                   io_v_i
   ,input  bridge_pkg::io_req_t    io_req_i

   ,input  logic                   pop_i
   ,output bridge_pkg::mbox_word_t data_o
   ,output logic                   empty_o
   ,output logic                   overflow_o
);

   import bridge_pkg::*;

   mbox_word_t                   mem_r [mbox_depth_lp];
   logic [mbox_ptr_width_lp-1:0] rd_ptr_r;
   logic [mbox_ptr_width_lp-1:0] wr_ptr_r;
   mbox_count_t                  count_r;
   logic                         overflow_r;

   mbox_word_t push_word;
   logic       full;
   logic       io_write;
   logic       push;
   logic       pop;

   assign push_word = '{v: 1'b1, addr: io_req_i.addr[22:0], data: io_req_i.data[7:0]};

   assign full     = count_r == mbox_count_t'(mbox_depth_lp);
   assign empty_o  = count_r == '0;
   assign io_write = io_v_i & io_req_i.we;

   // A pop frees a slot in the same cycle
   assign pop  = pop_i & ~empty_o;
   assign push = io_write & (~full | pop);

   always_ff @(posedge clk_i) begin
      if (sys_reset_i) begin
         rd_ptr_r <= '0;
         wr_ptr_r <= '0;
         count_r  <= '0;
      end else begin
         if (push)
            wr_ptr_r <= wr_ptr_r + 1'b1;
         if (pop)
            rd_ptr_r <= rd_ptr_r + 1'b1;
         if (push && !pop)
            count_r <= count_r + 1'b1;
         else if (pop && !push)
            count_r <= count_r - 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_r[wr_ptr_r] <= push_word;
      end
   end

   // Dropped writes are remembered until the next system reset
   always_ff @(posedge clk_i) begin
      if (sys_reset_i) begin
         overflow_r <= 1'b0;
      end else if (io_write && !push) begin
         overflow_r <= 1'b1;
      end
   end

   assign data_o     = mem_r[rd_ptr_r];
   assign overflow_o = overflow_r;

endmodule

//--- logic/zynq_bridge_top.sv
`timescale 1ns/1ps

module zynq_bridge_top (
   input  logic                                       clk_i
   ,input  logic                                      reset_i

   // Host register port
   ,input  logic                                      csr_wr_v_i
   ,input  bridge_pkg::csr_wr_t                       csr_wr_i
   ,input  logic                                      csr_rd_v_i
   ,input  bridge_pkg::csr_addr_e                     csr_rd_addr_i
   ,output logic                                      csr_rd_v_o
   ,output logic [bridge_pkg::reg_width_lp-1:0]       csr_rd_data_o

   // Host accesses into the core map
   ,input  logic                                      host_req_v_i
   ,input  bridge_pkg::host_req_t                     host_req_i
   ,output logic                                      core_req_v_o
   ,output logic [bridge_pkg::core_addr_width_lp-1:0] core_addr_o
   ,output logic                                      core_is_write_o

   // Core DRAM requests toward the PS
   ,input  logic                                      dram_req_v_i
   ,input  bridge_pkg::dram_req_t                     dram_req_i
   ,output logic                                      mem_req_v_o
   ,output logic [bridge_pkg::mem_addr_width_lp-1:0]  mem_addr_o
   ,output logic                                      mem_is_write_o

   // Core I/O to host mailbox
   ,input  logic                                      io_v_i
   ,input  bridge_pkg::io_req_t                       io_req_i
   ,input  logic                                      mbox_pop_i
   ,output bridge_pkg::mbox_word_t                    mbox_data_o
   ,output logic                                      mbox_empty_o

   ,output logic                                      sys_reset_o
   ,output logic                                      core_reset_o
);

   import bridge_pkg::*;

   logic [mem_addr_width_lp-1:0]    dram_base;
   logic [region_width_lp-1:0]      region;
   logic [footprint_regions_lp-1:0] footprint;
   logic                            high_seen;
   logic                            overflow;

   csr_bank i_csr (
      .clk_i          (clk_i)
      ,.reset_i       (reset_i)
      ,.csr_wr_v_i    (csr_wr_v_i)
      ,.csr_wr_i      (csr_wr_i)
      ,.csr_rd_v_i    (csr_rd_v_i)
      ,.csr_rd_addr_i (csr_rd_addr_i)
      ,.footprint_i   (footprint)
      ,.high_seen_i   (high_seen)
      ,.overflow_i    (overflow)
      ,.sys_reset_o   (sys_reset_o)
      ,.core_reset_o  (core_reset_o)
      ,.dram_base_o   (dram_base)
      ,.csr_rd_v_o    (csr_rd_v_o)
      ,.csr_rd_data_o (csr_rd_data_o)
   );

   addr_remap i_remap (
      .clk_i            (clk_i)
      ,.reset_i         (reset_i)
      ,.sys_reset_i     (sys_reset_o)
      ,.dram_base_i     (dram_base)
      ,.host_req_v_i    (host_req_v_i)
      ,.host_req_i      (host_req_i)
      ,.dram_req_v_i    (dram_req_v_i)
      ,.dram_req_i      (dram_req_i)
      ,.core_req_v_o    (core_req_v_o)
      ,.core_addr_o     (core_addr_o)
      ,.core_is_write_o (core_is_write_o)
      ,.mem_req_v_o     (mem_req_v_o)
      ,.mem_addr_o      (mem_addr_o)
      ,.mem_is_write_o  (mem_is_write_o)
      ,.region_o        (region)
      ,.high_seen_o     (high_seen)
   );

   // Marks the region of every request that goes out to DRAM
   mem_footprint i_footprint (
      .clk_i        (clk_i)
      ,.sys_reset_i (sys_reset_o)
      ,.mark_v_i    (mem_req_v_o)
      ,.region_i    (region)
      ,.footprint_o (footprint)
   );

   io_mailbox i_mailbox (
      .clk_i        (clk_i)
      ,.sys_reset_i (sys_reset_o)
      ,.io_v_i      (io_v_i)
      ,.io_req_i    (io_req_i)
      ,.pop_i       (mbox_pop_i)
      ,.data_o      (mbox_data_o)
      ,.empty_o     (mbox_empty_o)
      ,.overflow_o  (overflow)
   );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
   output logic clk_o
);

   // 8 ns period
   initial begin
      clk_o = 1'b0;
      forever #4 clk_o = ~clk_o;
   end

endmodule

//--- bench/bridge_props.sv
`timescale 1ns/1ps

module bridge_props (
   input  logic clk_i
   ,input logic reset_i
   ,input logic sys_reset_i
   ,input logic mem_req_v_i
   ,input logic rd_req_v_i
   ,input logic rd_resp_v_i
   ,input logic mbox_empty_i
);

   // DRAM traffic only leaves while the system runs
   no_dram_in_reset: assert property (
      @(posedge clk_i) disable iff (reset_i) sys_reset_i |-> !mem_req_v_i)
      else $error("DRAM request issued while the system is in reset");

   rd_answer_latency: assert property (
      @(posedge clk_i) disable iff (reset_i) rd_resp_v_i == $past(rd_req_v_i))
      else $error("Register read answer does not follow its request by one cycle");

   mbox_empty_after_reset: assert property (
      @(posedge clk_i) $fell(reset_i) |-> mbox_empty_i)
      else $error("Mailbox not empty in the cycle after reset");

endmodule

bind zynq_bridge_top bridge_props i_props (
   .clk_i         (clk_i)
   ,.reset_i      (reset_i)
   ,.sys_reset_i  (sys_reset_o)
   ,.mem_req_v_i  (mem_req_v_o)
   ,.rd_req_v_i   (csr_rd_v_i)
   ,.rd_resp_v_i  (csr_rd_v_o)
   ,.mbox_empty_i (mbox_empty_o)
);

//--- bench/bridge_tb.sv
`timescale 1ns/1ps

module bridge_tb;

   import bridge_pkg::*;

   localparam int rd_timeout_lp = 8;

   logic        clk_i;
   logic        reset_i;
   logic        csr_wr_v_i;
   csr_wr_t     csr_wr_i;
   logic        csr_rd_v_i;
   csr_addr_e   csr_rd_addr_i;
   logic        csr_rd_v_o;
   logic [31:0] csr_rd_data_o;
   logic        host_req_v_i;
   host_req_t   host_req_i;
   logic        core_req_v_o;
   logic [63:0] core_addr_o;
   logic        core_is_write_o;
   logic        dram_req_v_i;
   dram_req_t   dram_req_i;
   logic        mem_req_v_o;
   logic [31:0] mem_addr_o;
   logic        mem_is_write_o;
   logic        io_v_i;
   io_req_t     io_req_i;
   logic        mbox_pop_i;
   mbox_word_t  mbox_data_o;
   logic        mbox_empty_o;
   logic        sys_reset_o;
   logic        core_reset_o;

   // Requests launched last cycle and what they must produce
   logic        host_pend;
   logic [63:0] host_exp;
   logic        host_exp_w;
   logic        dram_pend;
   logic [31:0] dram_exp;
   logic        dram_exp_w;

   int                 fd;
   int                 line_no;
   int                 waited;
   string              op;
   logic [8*128-1:0]   rest;
   logic [63:0]        a;
   logic [63:0]        b;
   logic [63:0]        c;
   logic [31:0]        rand_addr;

   tb_clock i_clock (.clk_o(clk_i));

   zynq_bridge_top i_zynq_bridge_top (.*);

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      assert (act === exp) else begin
         $display("MISMATCH %s (pattern %0d) expected %h actual %h", name, line_no, exp, act);
         $display("Simulation failed");
         $fatal(1, "Stopping at the first error");
      end
   endtask

   task automatic clear_inputs();
      csr_wr_v_i   = 1'b0;
      csr_rd_v_i   = 1'b0;
      host_req_v_i = 1'b0;
      dram_req_v_i = 1'b0;
      io_v_i       = 1'b0;
      mbox_pop_i   = 1'b0;
   endtask

   // Advance one clock, then check what the previous cycle launched
   task automatic next_cycle();
      @(posedge clk_i);
      #1;
      check_value("core_req_v", {63'b0, host_pend}, {63'b0, core_req_v_o});
      if (host_pend) begin
         check_value("core_addr", host_exp, core_addr_o);
         check_value("core_is_write", {63'b0, host_exp_w}, {63'b0, core_is_write_o});
      end
      check_value("mem_req_v", {63'b0, dram_pend}, {63'b0, mem_req_v_o});
      if (dram_pend) begin
         check_value("mem_addr", {32'b0, dram_exp}, {32'b0, mem_addr_o});
         check_value("mem_is_write", {63'b0, dram_exp_w}, {63'b0, mem_is_write_o});
      end
      host_pend = 1'b0;
      dram_pend = 1'b0;
      clear_inputs();
   endtask

   initial begin
      void'($urandom(32'h9d8e));
      reset_i       = 1'b1;
      csr_wr_i      = '0;
      csr_rd_addr_i = CSR_SYS_RUN;
      host_req_i    = '0;
      dram_req_i    = '0;
      io_req_i      = '0;
      host_pend     = 1'b0;
      host_exp      = '0;
      host_exp_w    = 1'b0;
      dram_pend     = 1'b0;
      dram_exp      = '0;
      dram_exp_w    = 1'b0;
      line_no       = 0;
      clear_inputs();

      fd = $fopen("bench/bridge_patterns.txt", "r");
      if (fd == 0) begin
         $display("Simulation failed");
         $fatal(1, "Could not open the pattern file");
      end

      repeat (8) @(posedge clk_i);
      #1;
      reset_i = 1'b0;

      while ($fscanf(fd, "%s", op) == 1) begin
         if (op == "#") begin
            void'($fgets(rest, fd));
         end else begin
            if ($fscanf(fd, "%h %h %h", a, b, c) != 3) begin
               $display("Simulation failed");
               $fatal(1, "Pattern line for %s is missing operands", op);
            end
            line_no++;
            next_cycle();
            case (op)
               "wr": begin
                  csr_wr_v_i = 1'b1;
                  csr_wr_i   = '{addr: csr_addr_e'(a[2:0]), data: b[31:0]};
               end
               "rd": begin
                  csr_rd_v_i    = 1'b1;
                  csr_rd_addr_i = csr_addr_e'(a[2:0]);
                  waited        = 0;
                  do begin
                     next_cycle();
                     waited++;
                  end while (!csr_rd_v_o && waited < rd_timeout_lp);
                  if (!csr_rd_v_o) begin
                     $display("Simulation failed");
                     $fatal(1, "Timed out waiting for the register read answer");
                  end
                  check_value("csr read latency", 64'd1, 64'(waited));
                  check_value("csr read data", b, {32'b0, csr_rd_data_o});
               end
               "host", "hrand": begin
                  rand_addr    = (op == "host") ? b[31:0] : $urandom();
                  host_req_v_i = 1'b1;
                  host_req_i   = '{is_write: a[0], addr: rand_addr};
                  host_pend    = 1'b1;
                  host_exp_w   = a[0];
                  // Keep the low 28 bits, set bit 31 when host bit 29 is clear
                  host_exp     = (op == "host") ? c :
                     {32'b0, (rand_addr & 32'h0FFF_FFFF) |
                      (rand_addr[29] ? 32'h0 : 32'h8000_0000)};
               end
               "dram": begin
                  dram_req_v_i = 1'b1;
                  dram_req_i   = '{is_write: a[0], addr: b};
                  dram_pend    = 1'b1;
                  dram_exp     = c[31:0];
                  dram_exp_w   = a[0];
               end
               "io": begin
                  io_v_i   = 1'b1;
                  io_req_i = '{we: a[0], addr: b, data: c};
               end
               "pop": begin
                  check_value("mbox empty", a, {63'b0, mbox_empty_o});
                  if (!mbox_empty_o)
                     check_value("mbox head", b, {32'b0, mbox_data_o});
                  mbox_pop_i = 1'b1;
               end
               "resets": begin
                  check_value("sys_reset", a, {63'b0, sys_reset_o});
                  check_value("core_reset", b, {63'b0, core_reset_o});
               end
               "idle": begin
               end
               default: begin
                  $display("Simulation failed");
                  $fatal(1, "Unknown operation %s in the pattern file", op);
               end
            endcase
         end
      end
      next_cycle();
      $fclose(fd);

      $display("Simulation passed");
      $finish;
   end

endmodule

//--- zynq_bridge_top.f
logic/bridge_pkg.sv
logic/csr_bank.sv
logic/addr_remap.sv
logic/mem_footprint.sv
logic/io_mailbox.sv
logic/zynq_bridge_top.sv
bench/tb_clock.sv
bench/bridge_props.sv
bench/bridge_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the bridge testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module bridge_tb \
   -f zynq_bridge_top.f -o bridge_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/bridge_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation run ended with status $status"
fi
exit $status

//--- bench/bridge_patterns.txt
# op a b c in hex: wr addr data | rd addr expect | host/dram is_write addr expect | hrand is_write
# io we addr data | pop expect_empty expect_head | resets sys core | idle
resets 1 1 0
rd 0 0 0
rd 3 0 0
rd 4 0 0
wr 0 1 0
resets 0 1 0
wr 3 1 0
resets 0 0 0
wr 2 10000000 0
rd 0 1 0
rd 3 1 0
rd 2 10000000 0
host 0 00001234 0000000080001234
host 1 20001234 0000000000001234
hrand 1 0 0
dram 0 0000000080000000 10000000
dram 1 0000000080800000 10800000
dram 0 0000000081000040 11000040
dram 1 0000000087000000 17000000
idle 0 0 0
rd 4 4007 0
rd 1 0 0
dram 0 00000000a0000000 30000000
rd 1 1 0
rd 6 1 0
wr 0 0 0
resets 1 1 0
rd 4 0 0
rd 1 0 0
wr 0 1 0
pop 1 0 0
pop 1 0 0
io 1 0000000010001004 00000000000000a5
io 0 0000000000000008 00000000000000ff
io 1 0000000000000010 0000000000000142
pop 0 801004a5 0
pop 0 80001042 0
io 1 1 11
io 1 2 22
io 1 3 33
io 1 4 44
io 1 5 55
rd 1 2 0
pop 0 80000111 0
pop 0 80000222 0
pop 0 80000333 0
pop 0 80000444 0
pop 1 0 0
